// ==== apb_icb_subsys.f ====
+incdir+src
src/icb_pkg.sv
src/apb_icb_bridge.sv
src/icb_addr_router.sv
src/icb_sram.sv
src/icb_crc_regs.sv
src/apb_icb_subsys.sv
verification/tb_apb_icb_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the APB/ICB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_apb_icb_subsys
log=sim.log

verilator --binary --timing --top-module "$top" -f apb_icb_subsys.f \
	--Mdir obj_dir -o "V$top"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V$top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" "$log"; then
	exit 0
fi

echo "pass message not found in $log"
exit 1

// ==== src/apb_icb_bridge.sv ====
// =========================================================================
// APB slave to ICB master bridge
// setup phase issues one ICB command, access phase takes its response
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "icb_defs.svh"

module apb_icb_bridge (
	input wire aclk,
	input wire aresetn,
	// APB slave
	input wire [`ICB_ADDR_W-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [3:0] pstrb,
	input wire [31:0] pwdata,
	output logic pready,
	output logic pslverr,
	output logic [31:0] prdata,
	// ICB master, command channel
	output icb_pkg::icb_cmd_t cmd,
	output logic cmd_valid,
	input wire cmd_ready,
	// ICB master, response channel
	input wire icb_pkg::icb_rsp_t rsp,
	input wire rsp_valid,
	output logic rsp_ready
);

	// command already sent for the current transfer
	logic sent;

	// APB fields map straight onto the command
	assign cmd = '{addr: paddr, read: ~pwrite, wdata: pwdata, wmask: pstrb};
	// one command per transfer, only until it has gone out
	assign cmd_valid = psel & ~sent;

	// response is taken in the access phase
	assign rsp_ready = psel & penable;
	assign pready = rsp_valid & rsp_ready;
	assign pslverr = rsp.err;
	assign prdata = rsp.rdata;

	// set on the command handshake, cleared when the access phase ends
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			sent <= 1'b0;
		else if (pready)
			sent <= 1'b0;
		else if (cmd_valid & cmd_ready)
			sent <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== src/apb_icb_subsys.sv ====
// =========================================================================
// APB peripheral subsystem top level
// bridge, address router, SRAM slave and CRC register slave
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "icb_defs.svh"

module apb_icb_subsys (
	input wire aclk,
	input wire aresetn,
	input wire [`ICB_ADDR_W-1:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [3:0] pstrb,
	input wire [31:0] pwdata,
	output wire [31:0] prdata,
	output wire pready,
	output wire pslverr
);

	import icb_pkg::*;

	// bridge to router
	wire icb_cmd_t br_cmd;
	wire br_cmd_valid;
	wire br_cmd_ready;
	wire icb_rsp_t br_rsp;
	wire br_rsp_valid;
	wire br_rsp_ready;
	// router to SRAM
	wire icb_cmd_t sram_cmd;
	wire sram_cmd_valid;
	wire sram_cmd_ready;
	wire icb_rsp_t sram_rsp;
	wire sram_rsp_valid;
	wire sram_rsp_ready;
	// router to CRC registers
	wire icb_cmd_t crc_cmd;
	wire crc_cmd_valid;
	wire crc_cmd_ready;
	wire icb_rsp_t crc_rsp;
	wire crc_rsp_valid;
	wire crc_rsp_ready;

	apb_icb_bridge u_bridge (
		.aclk(aclk),
		.aresetn(aresetn),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pstrb(pstrb),
		.pwdata(pwdata),
		.pready(pready),
		.pslverr(pslverr),
		.prdata(prdata),
		.cmd(br_cmd),
		.cmd_valid(br_cmd_valid),
		.cmd_ready(br_cmd_ready),
		.rsp(br_rsp),
		.rsp_valid(br_rsp_valid),
		.rsp_ready(br_rsp_ready)
	);

	icb_addr_router u_router (
		.aclk(aclk),
		.aresetn(aresetn),
		.up_cmd(br_cmd),
		.up_cmd_valid(br_cmd_valid),
		.up_cmd_ready(br_cmd_ready),
		.up_rsp(br_rsp),
		.up_rsp_valid(br_rsp_valid),
		.up_rsp_ready(br_rsp_ready),
		.sram_cmd(sram_cmd),
		.sram_cmd_valid(sram_cmd_valid),
		.sram_cmd_ready(sram_cmd_ready),
		.sram_rsp(sram_rsp),
		.sram_rsp_valid(sram_rsp_valid),
		.sram_rsp_ready(sram_rsp_ready),
		.crc_cmd(crc_cmd),
		.crc_cmd_valid(crc_cmd_valid),
		.crc_cmd_ready(crc_cmd_ready),
		.crc_rsp(crc_rsp),
		.crc_rsp_valid(crc_rsp_valid),
		.crc_rsp_ready(crc_rsp_ready)
	);

	icb_sram #(
		.depth_log2(`SRAM_AW)
	) u_sram (
		.aclk(aclk),
		.aresetn(aresetn),
		.cmd(sram_cmd),
		.cmd_valid(sram_cmd_valid),
		.cmd_ready(sram_cmd_ready),
		.rsp(sram_rsp),
		.rsp_valid(sram_rsp_valid),
		.rsp_ready(sram_rsp_ready)
	);

	icb_crc_regs u_crc_regs (
		.aclk(aclk),
		.aresetn(aresetn),
		.cmd(crc_cmd),
		.cmd_valid(crc_cmd_valid),
		.cmd_ready(crc_cmd_ready),
		.rsp(crc_rsp),
		.rsp_valid(crc_rsp_valid),
		.rsp_ready(crc_rsp_ready)
	);

endmodule

`default_nettype wire

// ==== src/icb_addr_router.sv ====
// =========================================================================
// ICB address router, one upstream master to two slaves
// region decode, command steering, response merge
// local error responder for unmapped addresses
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "icb_defs.svh"

module icb_addr_router (
	input wire aclk,
	input wire aresetn,
	// upstream port from the bridge
	input wire icb_pkg::icb_cmd_t up_cmd,
	input wire up_cmd_valid,
	output logic up_cmd_ready,
	output icb_pkg::icb_rsp_t up_rsp,
	output logic up_rsp_valid,
	input wire up_rsp_ready,
	// SRAM slave
	output icb_pkg::icb_cmd_t sram_cmd,
	output logic sram_cmd_valid,
	input wire sram_cmd_ready,
	input wire icb_pkg::icb_rsp_t sram_rsp,
	input wire sram_rsp_valid,
	output logic sram_rsp_ready,
	// CRC register slave
	output icb_pkg::icb_cmd_t crc_cmd,
	output logic crc_cmd_valid,
	input wire crc_cmd_ready,
	input wire icb_pkg::icb_rsp_t crc_rsp,
	input wire crc_rsp_valid,
	output logic crc_rsp_ready
);

	import icb_pkg::*;

	localparam int addr_w = `ICB_ADDR_W;
	// lowest address bit above each region's span
	localparam int sram_lsb = `SRAM_AW + 2;
	localparam int crc_lsb = `CRC_AW;
	localparam logic [addr_w-1:0] sram_base = `SRAM_BASE;
	localparam logic [addr_w-1:0] crc_base = `CRC_BASE;

	icb_target_e dec_tgt;
	icb_target_e pend_tgt;
	logic cmd_hs;
	// local error response waiting for upstream ready
	logic err_valid;

	// region decode of the incoming command
	always_comb
	begin
		if (up_cmd.addr[addr_w-1:sram_lsb] == sram_base[addr_w-1:sram_lsb])
			dec_tgt = tgt_sram;
		else if (up_cmd.addr[addr_w-1:crc_lsb] == crc_base[addr_w-1:crc_lsb])
			dec_tgt = tgt_crc;
		else
			dec_tgt = tgt_none;
	end

	// command struct goes to both slaves, valid only to the chosen one
	assign sram_cmd = up_cmd;
	assign crc_cmd = up_cmd;
	assign sram_cmd_valid = up_cmd_valid & (dec_tgt == tgt_sram);
	assign crc_cmd_valid = up_cmd_valid & (dec_tgt == tgt_crc);

	// ready comes back from the chosen path only
	always_comb
	begin
		case (dec_tgt)
			tgt_sram: up_cmd_ready = sram_cmd_ready;
			tgt_crc: up_cmd_ready = crc_cmd_ready;
			default: up_cmd_ready = ~err_valid;
		endcase
	end

	assign cmd_hs = up_cmd_valid & up_cmd_ready;

	// single outstanding command, so one pending target is enough
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			pend_tgt <= tgt_none;
		else if (cmd_hs)
			pend_tgt <= dec_tgt;
	end

	// error responder answers one cycle after an unmapped command
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			err_valid <= 1'b0;
		else if (err_valid & up_rsp_ready)
			err_valid <= 1'b0;
		else if (cmd_hs & (dec_tgt == tgt_none))
			err_valid <= 1'b1;
	end

	// response merge, selected by the registered target
	always_comb
	begin
		case (pend_tgt)
			tgt_sram:
			begin
				up_rsp = sram_rsp;
				up_rsp_valid = sram_rsp_valid;
			end
			tgt_crc:
			begin
				up_rsp = crc_rsp;
				up_rsp_valid = crc_rsp_valid;
			end
			default:
			begin
				up_rsp = '{rdata: 32'h0, err: 1'b1};
				up_rsp_valid = err_valid;
			end
		endcase
	end

	// only the slave that owns the pending response sees ready
	assign sram_rsp_ready = up_rsp_ready & (pend_tgt == tgt_sram);
	assign crc_rsp_ready = up_rsp_ready & (pend_tgt == tgt_crc);

endmodule

`default_nettype wire

// ==== src/icb_crc_regs.sv ====
// =========================================================================
// ICB CRC-32 register slave
// control, data, value and scratch registers
// one-cycle CRC over a written data word, registered response
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "icb_defs.svh"

module icb_crc_regs (
	input wire aclk,
	input wire aresetn,
	input wire icb_pkg::icb_cmd_t cmd,
	input wire cmd_valid,
	output logic cmd_ready,
	output icb_pkg::icb_rsp_t rsp,
	output logic rsp_valid,
	input wire rsp_ready
);

	import icb_pkg::*;

	localparam int crc_aw = `CRC_AW;

	crc_reg_e reg_sel;
	logic off_bad;
	logic cmd_err;
	logic cmd_hs;
	logic wr_ok;
	logic [31:0] crc_q;
	logic [31:0] scratch_q;
	logic [31:0] rd_word;
	logic [31:0] rdata_q;
	logic err_q;

	// reflected CRC-32 over one word, lowest byte first, LSB first
	function automatic logic [31:0] crc32_word(input logic [31:0] crc_in,
		input logic [31:0] data);
		logic [31:0] c;
		c = crc_in ^ data;
		for (int i = 0; i < 32; i++)
			c = c[0] ? ((c >> 1) ^ `CRC_POLY) : (c >> 1);
		return c;
	endfunction

	// word offset inside the register window
	assign reg_sel = crc_reg_e'({cmd.addr[3:2], 2'b00});
	// anything past 0xC in the window
	assign off_bad = |cmd.addr[crc_aw-1:4];

	// illegal accesses, none of them touch state
	assign cmd_err = off_bad
		| (~cmd.read & (reg_sel == reg_value))
		| (~cmd.read & (reg_sel == reg_data) & (cmd.wmask != 4'hF));

	assign cmd_ready = ~rsp_valid;
	assign cmd_hs = cmd_valid & cmd_ready;
	assign wr_ok = cmd_hs & ~cmd.read & ~cmd_err;

	// remainder: restart from ctrl bit 0, advance on a data write
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			crc_q <= 32'hFFFF_FFFF;
		else if (wr_ok & (reg_sel == reg_ctrl) & cmd.wdata[0])
			crc_q <= 32'hFFFF_FFFF;
		else if (wr_ok & (reg_sel == reg_data))
			crc_q <= crc32_word(crc_q, cmd.wdata);
	end

	// scratch, byte-masked
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			scratch_q <= 32'h0;
		else if (wr_ok & (reg_sel == reg_scratch))
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (cmd.wmask[b])
					scratch_q[8*b +: 8] <= cmd.wdata[8*b +: 8];
			end
		end
	end

	// read mux, ctrl and data read as zero
	always_comb
	begin
		case (reg_sel)
			reg_value: rd_word = ~crc_q;
			reg_scratch: rd_word = scratch_q;
			default: rd_word = 32'h0;
		endcase
	end

	// response payload, zero data on writes and errors
	always_ff @(posedge aclk)
	begin
		if (cmd_hs)
		begin
			rdata_q <= (cmd.read & ~cmd_err) ? rd_word : 32'h0;
			err_q <= cmd_err;
		end
	end

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			rsp_valid <= 1'b0;
		else if (cmd_hs)
			rsp_valid <= 1'b1;
		else if (rsp_ready)
			rsp_valid <= 1'b0;
	end

	assign rsp = '{rdata: rdata_q, err: err_q};

endmodule

`default_nettype wire

// ==== src/icb_defs.svh ====
// =========================================================================
// shared constants of the APB/ICB peripheral subsystem
// byte address width, SRAM size, region map, CRC-32 polynomial
// =========================================================================
`ifndef ICB_DEFS_SVH
`define ICB_DEFS_SVH

// byte address width of every ICB link and of paddr
`define ICB_ADDR_W 16

// log2 of the SRAM word count, 256 words of 32 bits = 1 KB
`define SRAM_AW 8

// region bases
`define SRAM_BASE 16'h0000
`define CRC_BASE 16'h1000

// log2 of the byte span decoded for the register region
// only the first sixteen bytes hold registers
`define CRC_AW 8

// reflected CRC-32 polynomial (IEEE 802.3)
`define CRC_POLY 32'hEDB88320

`endif

// ==== src/icb_pkg.sv ====
// =========================================================================
// ICB types shared by the bridge, the router, the slaves and the testbench
// command / response structs, routing target and register offsets
// =========================================================================
`default_nettype none

`include "icb_defs.svh"

package icb_pkg;

	// one ICB command beat
	typedef struct packed {
		logic [`ICB_ADDR_W-1:0] addr;
		logic read;
		logic [31:0] wdata;
		logic [3:0] wmask;
	} icb_cmd_t;

	// one ICB response beat
	typedef struct packed {
		logic [31:0] rdata;
		logic err;
	} icb_rsp_t;

	// where the router sent a command
	typedef enum logic [1:0] {
		tgt_sram,
		tgt_crc,
		tgt_none
	} icb_target_e;

	// byte offsets inside the CRC register block
	typedef enum logic [3:0] {
		reg_ctrl = 4'h0,
		reg_data = 4'h4,
		reg_value = 4'h8,
		reg_scratch = 4'hC
	} crc_reg_e;

endpackage

`default_nettype wire

// ==== src/icb_sram.sv ====
// =========================================================================
// ICB SRAM slave
// word array with byte write masks, registered one-cycle response
// =========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "icb_defs.svh"

module icb_sram #(
	parameter int depth_log2 = `SRAM_AW
) (
	input wire aclk,
	input wire aresetn,
	input wire icb_pkg::icb_cmd_t cmd,
	input wire cmd_valid,
	output logic cmd_ready,
	output icb_pkg::icb_rsp_t rsp,
	output logic rsp_valid,
	input wire rsp_ready
);

	logic [31:0] mem [0:(1 << depth_log2)-1];
	logic [depth_log2-1:0] widx;
	logic cmd_hs;
	logic [31:0] rdata_q;

	// word index from the byte address
	assign widx = cmd.addr[depth_log2+1:2];

	// no new command while a response is still waiting
	assign cmd_ready = ~rsp_valid;
	assign cmd_hs = cmd_valid & cmd_ready;

	// byte-masked write
	always_ff @(posedge aclk)
	begin
		if (cmd_hs & ~cmd.read)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (cmd.wmask[b])
					mem[widx][8*b +: 8] <= cmd.wdata[8*b +: 8];
			end
		end
	end

	// read data captured with the command, writes answer zero
	always_ff @(posedge aclk)
	begin
		if (cmd_hs)
			rdata_q <= cmd.read ? mem[widx] : 32'h0;
	end

	// response held until upstream takes it
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			rsp_valid <= 1'b0;
		else if (cmd_hs)
			rsp_valid <= 1'b1;
		else if (rsp_ready)
			rsp_valid <= 1'b0;
	end

	// range errors are the router's job, this slave never flags one
	assign rsp = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== verification/apb_icb_stim.txt ====
# columns, all hex: op (0 read, 1 write) addr pstrb pwdata exp_prdata exp_pslverr
# SRAM full write, read back, masked merge, top word
1 0000 f 11223344 00000000 0
0 0000 0 00000000 11223344 0
1 0000 5 aabbccdd 00000000 0
0 0000 0 00000000 11bb33dd 0
1 03fc f cafef00d 00000000 0
0 03fc 0 00000000 cafef00d 0
# scratch register, full then single-byte write
1 100c f 12345678 00000000 0
1 100c 2 0000ab00 00000000 0
0 100c 0 00000000 1234ab78 0
# CRC restart, empty value, one word holding "1234", ctrl reads zero
1 1000 1 00000001 00000000 0
0 1008 0 00000000 00000000 0
1 1004 f 34333231 00000000 0
0 1008 0 00000000 9be3e0a3 0
0 1000 0 00000000 00000000 0
# error responses: unmapped, SRAM past 1 KB, value write, partial data, offset 0x10
0 2000 0 00000000 00000000 1
1 0400 f deadbeef 00000000 1
1 1008 f 00000000 00000000 1
1 1004 3 ffffffff 00000000 1
0 1010 0 00000000 00000000 1
# state untouched by the errors above
0 1008 0 00000000 9be3e0a3 0
0 0000 0 00000000 11bb33dd 0
0 100c 0 00000000 1234ab78 0

// ==== verification/tb_apb_icb_subsys.sv ====
// ==========================================================================
// testbench for the APB peripheral subsystem
// clock and reset, stim file reader, APB transfer driver
// compare tasks, watchdog and error summary
// ==========================================================================
`timescale 1ns/1ns
`default_nettype none

`include "icb_defs.svh"

module tb_apb_icb_subsys;

	import icb_pkg::*;

	localparam int clk_period = 40;
	localparam int reset_cycles = 10;

	// one APB transfer with its expected response
	typedef struct packed {
		logic write;
		logic [`ICB_ADDR_W-1:0] addr;
		logic [3:0] strb;
		logic [31:0] wdata;
		logic [31:0] exp_rdata;
		logic exp_err;
	} xfer_t;

	logic aclk;
	logic aresetn;
	logic [`ICB_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] pstrb;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;

	xfer_t xfers[$];
	bit stim_loaded;
	int value_errs;
	int ready_errs;

	apb_icb_subsys u_apb_icb_subsys (
		.aclk(aclk),
		.aresetn(aresetn),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pstrb(pstrb),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #(clk_period / 2) aclk = ~aclk;

	// response payload as seen on prdata / pslverr
	task automatic check_rsp(input icb_rsp_t exp, input icb_rsp_t act,
		input logic [`ICB_ADDR_W-1:0] addr);
		if (act.rdata !== exp.rdata)
		begin
			value_errs++;
			$display("[ERROR] prdata at 0x%04h expected 0x%08h got 0x%08h",
				addr, exp.rdata, act.rdata);
		end
		if (act.err !== exp.err)
		begin
			value_errs++;
			$display("[ERROR] pslverr at 0x%04h expected 0x%01h got 0x%01h",
				addr, exp.err, act.err);
		end
	endtask

	// no wait states, so pready must be up in the access cycle
	task automatic check_ready(input logic act, input logic [`ICB_ADDR_W-1:0] addr);
		if (act !== 1'b1)
		begin
			ready_errs++;
			$display("transfer to address 0x%04h did not complete in its second cycle", addr);
		end
	endtask

	task automatic load_stim(output bit ok);
		int fd;
		int n;
		string line;
		logic f_op;
		logic [`ICB_ADDR_W-1:0] f_addr;
		logic [3:0] f_strb;
		logic [31:0] f_wdata;
		logic [31:0] f_rdata;
		logic f_err;
		ok = 1'b0;
		fd = $fopen("verification/apb_icb_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verification/apb_icb_stim.txt");
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			// skip column notes and blank lines
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_strb, f_wdata,
				f_rdata, f_err);
			if (n == 6)
				xfers.push_back('{write: f_op, addr: f_addr, strb: f_strb,
					wdata: f_wdata, exp_rdata: f_rdata, exp_err: f_err});
		end
		$fclose(fd);
		ok = (xfers.size() > 0);
	endtask

	// setup phase then access phase, each driven 1 ns after the edge
	task automatic apb_transfer(input xfer_t x);
		icb_rsp_t exp;
		icb_rsp_t got;
		@(posedge aclk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = x.write;
		paddr = x.addr;
		pstrb = x.strb;
		pwdata = x.wdata;
		@(posedge aclk);
		#1;
		penable = 1'b1;
		// mid access cycle, response path is settled here
		@(negedge aclk);
		exp.rdata = x.exp_rdata;
		exp.err = x.exp_err;
		got.rdata = prdata;
		got.err = pslverr;
		check_ready(pready, x.addr);
		check_rsp(exp, got, x.addr);
	endtask

	initial
	begin
		bit loaded;
		aclk = 1'b0;
		aresetn = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pstrb = 4'h0;
		pwdata = 32'h0;
		value_errs = 0;
		ready_errs = 0;
		stim_loaded = 1'b0;
		load_stim(loaded);
		if (!loaded)
		begin
			$display("no transfers could be read from the stim file");
			$display("Regression failed");
			$finish;
		end
		else
		begin
			stim_loaded = 1'b1;
			repeat (reset_cycles) @(posedge aclk);
			#1;
			aresetn = 1'b1;
			foreach (xfers[i])
				apb_transfer(xfers[i]);
			// bus back to idle after the last access
			@(posedge aclk);
			#1;
			psel = 1'b0;
			penable = 1'b0;
			@(posedge aclk);
			$display("%0d transfers, %0d value errors, %0d incomplete transfers",
				xfers.size(), value_errs, ready_errs);
			if (value_errs == 0 && ready_errs == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
			$finish;
		end
	end

	// watchdog, two cycles per transfer plus twenty transfers of slack
	initial
	begin
		longint limit_ns;
		wait (stim_loaded);
		limit_ns = longint'(xfers.size() + 20) * 2 * clk_period;
		#(limit_ns);
		$display("timed out: the run did not finish within %0d ns", limit_ns);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
